//--- coleco_ctrl.f
hw/cv_pkg.sv
hw/ps2_pkg.sv
hw/cv_port_if.sv
hw/ps2_keypad_emu.sv
hw/pad_router.sv
hw/cv_port_encoder.sv
hw/ctrl_apb_regs.sv
hw/coleco_ctrl_top.sv
dv/coleco_ctrl_props.sv
dv/coleco_ctrl_tb.sv

//--- dv/coleco_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module coleco_ctrl_props
        import cv_pkg::*;
(
        input wire              clk_sys,
        input wire              rst_i,
        input wire              psel_i,
        input wire              penable_i,
        input wire              pready_o,
        input wire              pslverr_o,
        input wire [CTRL_W-1:0] ctrl_q
);

        // Zero-wait slave
        a_pready: assert property (@(posedge clk_sys)
                (psel_i && penable_i) |-> pready_o)
                else $error("pready low in an access phase");

        a_slverr: assert property (@(posedge clk_sys)
                !(psel_i && penable_i) |-> !pslverr_o)
                else $error("pslverr high outside an access phase");

        a_ctrl_reset: assert property (@(posedge clk_sys)
                rst_i |=> (ctrl_q == '0))
                else $error("CTRL not cleared by reset");

endmodule

bind ctrl_apb_regs coleco_ctrl_props u_props (
        .clk_sys   (clk_sys),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .ctrl_q    (ctrl_q)
);

`default_nettype wire

//--- dv/coleco_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module coleco_ctrl_tb
        import cv_pkg::*;
        import ps2_pkg::*;
();

        localparam int     ITER       = 2000;
        localparam longint TIMEOUT_NS = ITER * 8 * 40;

        localparam scan_code_t KNOWN_CODES [24] = '{
                SC_TOP_0, SC_TOP_1, SC_TOP_2, SC_TOP_3, SC_TOP_4,
                SC_TOP_5, SC_TOP_6, SC_TOP_7, SC_TOP_8, SC_TOP_9,
                SC_PAD_0, SC_PAD_1, SC_PAD_2, SC_PAD_3, SC_PAD_4,
                SC_PAD_5, SC_PAD_6, SC_PAD_7, SC_PAD_8, SC_PAD_9,
                SC_STAR, SC_LSHIFT, SC_RSHIFT, SC_MINUS
        };

        logic       clk_sys;
        logic       rst_i;
        apb_addr_t  paddr;
        logic       psel;
        logic       penable;
        logic       pwrite;
        apb_data_t  pwdata;
        apb_data_t  prdata;
        logic       pready;
        logic       pslverr;
        ps2_event_t ps2_key;
        joy_t       joy0;
        joy_t       joy1;
        logic       p1_kp_n;
        logic       p1_joy_n;
        port_code_t p1_lines;
        logic       p1_fire_n;
        logic       p2_kp_n;
        logic       p2_joy_n;
        port_code_t p2_lines;
        logic       p2_fire_n;

        // Reference model state
        logic [1:0] m_ctrl;
        kbd_btn_t   m_btn;

        coleco_ctrl_top UUT (
                .clk_sys           (clk_sys),
                .rst_i             (rst_i),
                .paddr_i           (paddr),
                .psel_i            (psel),
                .penable_i         (penable),
                .pwrite_i          (pwrite),
                .pwdata_i          (pwdata),
                .prdata_o          (prdata),
                .pready_o          (pready),
                .pslverr_o         (pslverr),
                .ps2_key_i         (ps2_key),
                .joy0_i            (joy0),
                .joy1_i            (joy1),
                .p1_strobe_kp_n_i  (p1_kp_n),
                .p1_strobe_joy_n_i (p1_joy_n),
                .p1_lines_o        (p1_lines),
                .p1_fire_n_o       (p1_fire_n),
                .p2_strobe_kp_n_i  (p2_kp_n),
                .p2_strobe_joy_n_i (p2_joy_n),
                .p2_lines_o        (p2_lines),
                .p2_fire_n_o       (p2_fire_n)
        );

        initial begin
                clk_sys = 1'b0;
                forever #20 clk_sys = ~clk_sys;
        end

        initial begin
                #(TIMEOUT_NS);
                $display("Watchdog expired before all tests finished");
                $display("TESTBENCH FAILED");
                $fatal(1, "Timeout");
        end

        task automatic check_eq(input string name, input apb_data_t exp, input apb_data_t act);
                assert (act === exp) else begin
                        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "Stopping at first error");
                end
        endtask

        // ========================================
        // Reference model
        // ========================================
        function automatic int key_index(input scan_code_t sc);
                case (sc)
                        SC_TOP_0, SC_PAD_0:   return 0;
                        SC_TOP_1, SC_PAD_1:   return 1;
                        SC_TOP_2, SC_PAD_2:   return 2;
                        SC_TOP_3, SC_PAD_3:   return 3;
                        SC_TOP_4, SC_PAD_4:   return 4;
                        SC_TOP_5, SC_PAD_5:   return 5;
                        SC_TOP_6, SC_PAD_6:   return 6;
                        SC_TOP_7, SC_PAD_7:   return 7;
                        SC_TOP_8, SC_PAD_8:   return 8;
                        SC_TOP_9, SC_PAD_9:   return 9;
                        SC_STAR:              return BTN_STAR;
                        SC_LSHIFT, SC_RSHIFT: return BTN_SHIFT;
                        SC_MINUS:             return BTN_MINUS;
                        default:              return -1;
                endcase
        endfunction

        function automatic port_code_t port_code_of(input int idx);
                case (idx)
                        0:       return KEY_0;
                        1:       return KEY_1;
                        2:       return KEY_2;
                        3:       return KEY_3;
                        4:       return KEY_4;
                        5:       return KEY_5;
                        6:       return KEY_6;
                        7:       return KEY_7;
                        8:       return KEY_8;
                        9:       return KEY_9;
                        10:      return KEY_STAR;
                        11:      return KEY_NUMBER;
                        12:      return KEY_PT;
                        13:      return KEY_BT;
                        default: return KEY_NONE;
                endcase
        endfunction

        // Fire 2, fire 1, right, left, down, up, blue, purple, number, star, digits
        function automatic keypad_t expected_keypad(input joy_t j);
                keypad_t kp;

                kp = {j[5], j[4], j[0], j[1], j[2], j[3], j[19], j[18], j[7], j[6], j[17:8]};
                if (m_ctrl[1]) begin
                        kp[9:0] = kp[9:0] | m_btn[9:0];
                        kp[10]  = kp[10] | m_btn[10] | (m_btn[11] & m_btn[8]);
                        kp[11]  = kp[11] | m_btn[12] | (m_btn[11] & m_btn[3]);
                end
                return kp;
        endfunction

        // Returns {lines, fire_n}
        function automatic logic [4:0] expected_port(input joy_t j, input logic kp_n,
                                                     input logic joy_n);
                keypad_t    kp;
                port_code_t code;
                port_code_t kp_lines;
                port_code_t joy_lines;
                logic       found;

                kp    = expected_keypad(j);
                code  = KEY_NONE;
                found = 1'b0;
                for (int i = 0; i <= 13; i++) begin
                        if (kp[i] && !found) begin
                                code  = port_code_of(i);
                                found = 1'b1;
                        end
                end
                kp_lines  = kp_n ? 4'hF : code;
                joy_lines = joy_n ? 4'hF : ~kp[17:14];
                joy_lines = {joy_lines[0], joy_lines[1], joy_lines[2], joy_lines[3]};
                return {kp_lines & joy_lines, (kp_n | ~kp[19]) & (joy_n | ~kp[18])};
        endfunction

        task automatic check_ports(input string name);
                joy_t j1;
                joy_t j2;

                j1 = m_ctrl[0] ? joy1 : joy0;
                j2 = m_ctrl[0] ? joy0 : joy1;
                check_eq({name, " port 1"}, 32'(expected_port(j1, p1_kp_n, p1_joy_n)),
                         32'({p1_lines, p1_fire_n}));
                check_eq({name, " port 2"}, 32'(expected_port(j2, p2_kp_n, p2_joy_n)),
                         32'({p2_lines, p2_fire_n}));
        endtask

        // ========================================
        // Stimulus helpers
        // ========================================
        function automatic joy_t sparse_joy();
                logic [31:0] r;

                r = $urandom & $urandom & $urandom;
                return r[19:0];
        endfunction

        // Called right after a rising edge
        task automatic drive_ports(input logic with_joys);
                logic [31:0] r;

                r = $urandom;
                p1_kp_n  <= r[0];
                p1_joy_n <= r[1];
                p2_kp_n  <= r[2];
                p2_joy_n <= r[3];
                joy0     <= with_joys ? sparse_joy() : '0;
                joy1     <= with_joys ? sparse_joy() : '0;
        endtask

        task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                                  output apb_data_t rdata, output logic err);
                @(posedge clk_sys);
                paddr   <= addr;
                pwrite  <= wr;
                pwdata  <= wdata;
                psel    <= 1'b1;
                penable <= 1'b0;
                @(posedge clk_sys);
                penable <= 1'b1;
                @(negedge clk_sys);
                check_eq("apb pready", 32'd1, 32'(pready));
                rdata = prdata;
                err   = pslverr;
                @(posedge clk_sys);
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
        endtask

        task automatic write_and_check(input string name, input apb_addr_t addr,
                                       input apb_data_t data);
                apb_data_t rdata;
                logic      err;
                logic      exp_err;

                exp_err = (addr != ADDR_CTRL) && (addr != ADDR_KEYS);
                apb_access(addr, 1'b1, data, rdata, err);
                check_eq({name, " pslverr"}, 32'(exp_err), 32'(err));
                if (addr == ADDR_CTRL) begin
                        m_ctrl = data[1:0];
                end
        endtask

        task automatic read_and_check(input string name, input apb_addr_t addr);
                apb_data_t rdata;
                logic      err;
                logic      exp_err;

                exp_err = (addr != ADDR_CTRL) && (addr != ADDR_KEYS);
                apb_access(addr, 1'b0, '0, rdata, err);
                check_eq({name, " pslverr"}, 32'(exp_err), 32'(err));
                if (addr == ADDR_CTRL) begin
                        check_eq({name, " ctrl"}, 32'(m_ctrl), rdata);
                end else if (addr == ADDR_KEYS) begin
                        check_eq({name, " keys"}, 32'(m_btn), rdata);
                end
        endtask

        // ========================================
        // Test sequence
        // ========================================
        initial begin
                logic [31:0] r;
                logic        flip;
                scan_code_t  sc;
                int          idx;

                void'($urandom(32'h9723bfc0));
                rst_i    = 1'b1;
                paddr    = '0;
                psel     = 1'b0;
                penable  = 1'b0;
                pwrite   = 1'b0;
                pwdata   = '0;
                ps2_key  = '0;
                joy0     = '0;
                joy1     = '0;
                p1_kp_n  = 1'b1;
                p1_joy_n = 1'b1;
                p2_kp_n  = 1'b1;
                p2_joy_n = 1'b1;
                m_ctrl   = '0;
                m_btn    = '0;

                repeat (3) @(posedge clk_sys);
                rst_i <= 1'b0;

                // Register block after reset
                read_and_check("reset ctrl", ADDR_CTRL);
                read_and_check("reset keys", ADDR_KEYS);
                @(negedge clk_sys);
                check_eq("idle port 1", 32'({KEY_NONE, 1'b1}), 32'({p1_lines, p1_fire_n}));
                check_eq("idle port 2", 32'({KEY_NONE, 1'b1}), 32'({p2_lines, p2_fire_n}));
                for (int i = 0; i < 40; i++) begin
                        write_and_check("ctrl write", ADDR_CTRL, $urandom);
                        read_and_check("ctrl readback", ADDR_CTRL);
                end
                for (int i = 0; i < 40; i++) begin
                        r = $urandom;
                        if (r[4]) begin
                                write_and_check("random write", r[3:0], $urandom);
                        end else begin
                                read_and_check("random read", r[3:0]);
                        end
                end
                write_and_check("keys write", ADDR_KEYS, $urandom);
                read_and_check("keys after write", ADDR_KEYS);

                // Port strobes, game-pad remap and swap
                for (int i = 0; i < ITER / 2; i++) begin
                        r = $urandom;
                        if (r[2:0] == 3'b000) begin
                                write_and_check("swap write", ADDR_CTRL, {30'b0, r[4:3]});
                                @(negedge clk_sys);
                                check_ports("after ctrl write");
                        end
                        @(posedge clk_sys);
                        drive_ports(1'b1);
                        @(negedge clk_sys);
                        check_ports("port mux");
                end

                // PS/2 keypad emulation
                write_and_check("kbd enable", ADDR_CTRL, 32'h2);
                for (int i = 0; i < ITER / 2; i++) begin
                        r = $urandom;
                        if (i % 64 == 63) begin
                                write_and_check("kbd enable change", ADDR_CTRL,
                                                {30'b0, r[17:16]});
                        end
                        flip = r[1:0] != 2'b00;
                        sc   = (r[5:3] != 3'b000) ? KNOWN_CODES[$urandom % 24] : r[15:8];
                        @(posedge clk_sys);
                        ps2_key <= {ps2_key[PS2_TOGGLE] ^ flip, r[2], r[6], sc};
                        drive_ports(r[7]);
                        @(negedge clk_sys);
                        check_ports("before key capture");
                        idx = key_index(sc);
                        if (flip && idx >= 0) begin
                                m_btn[idx] = r[2];
                        end
                        @(posedge clk_sys);
                        @(negedge clk_sys);
                        check_ports("after key capture");
                        read_and_check("keys", ADDR_KEYS);
                end

                $display("TESTBENCH PASSED");
                $finish;
        end

endmodule

`default_nettype wire

//--- hw/coleco_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module coleco_ctrl_top
        import cv_pkg::*;
        import ps2_pkg::*;
(
        input  wire        clk_sys,
        input  wire        rst_i,

        // APB
        input  apb_addr_t  paddr_i,
        input  wire        psel_i,
        input  wire        penable_i,
        input  wire        pwrite_i,
        input  apb_data_t  pwdata_i,
        output apb_data_t  prdata_o,
        output wire        pready_o,
        output wire        pslverr_o,

        input  ps2_event_t ps2_key_i,
        input  joy_t       joy0_i,
        input  joy_t       joy1_i,

        // Controller port 1
        input  wire        p1_strobe_kp_n_i,
        input  wire        p1_strobe_joy_n_i,
        output port_code_t p1_lines_o,
        output wire        p1_fire_n_o,

        // Controller port 2
        input  wire        p2_strobe_kp_n_i,
        input  wire        p2_strobe_joy_n_i,
        output port_code_t p2_lines_o,
        output wire        p2_fire_n_o
);

        kbd_btn_t kbd_btn;
        logic     swap;
        logic     kbd_en;
        keypad_t  keypad_a;
        keypad_t  keypad_b;

        cv_port_if p1_if ();
        cv_port_if p2_if ();

        ctrl_apb_regs u_regs (
                .clk_sys   (clk_sys),
                .rst_i     (rst_i),
                .paddr_i   (paddr_i),
                .psel_i    (psel_i),
                .penable_i (penable_i),
                .pwrite_i  (pwrite_i),
                .pwdata_i  (pwdata_i),
                .prdata_o  (prdata_o),
                .pready_o  (pready_o),
                .pslverr_o (pslverr_o),
                .kbd_btn_i (kbd_btn),
                .swap_o    (swap),
                .kbd_en_o  (kbd_en)
        );

        ps2_keypad_emu u_kbd (
                .clk_sys   (clk_sys),
                .rst_i     (rst_i),
                .ps2_key_i (ps2_key_i),
                .kbd_btn_o (kbd_btn)
        );

        pad_router u_router (
                .swap_i     (swap),
                .kbd_en_i   (kbd_en),
                .kbd_btn_i  (kbd_btn),
                .joy0_i     (joy0_i),
                .joy1_i     (joy1_i),
                .keypad_a_o (keypad_a),
                .keypad_b_o (keypad_b)
        );

        // ========================================
        // Controller ports
        // ========================================
        assign p1_if.strobe_kp_n  = p1_strobe_kp_n_i;
        assign p1_if.strobe_joy_n = p1_strobe_joy_n_i;
        assign p1_lines_o         = p1_if.lines;
        assign p1_fire_n_o        = p1_if.fire_n;

        assign p2_if.strobe_kp_n  = p2_strobe_kp_n_i;
        assign p2_if.strobe_joy_n = p2_strobe_joy_n_i;
        assign p2_lines_o         = p2_if.lines;
        assign p2_fire_n_o        = p2_if.fire_n;

        cv_port_encoder port_enc_1 (
                .keypad_i (keypad_a),
                .port     (p1_if.encoder)
        );

        cv_port_encoder port_enc_2 (
                .keypad_i (keypad_b),
                .port     (p2_if.encoder)
        );

endmodule

`default_nettype wire

//--- hw/ctrl_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_apb_regs
        import cv_pkg::*;
(
        input  wire       clk_sys,
        input  wire       rst_i,

        // APB slave, zero wait states
        input  apb_addr_t paddr_i,
        input  wire       psel_i,
        input  wire       penable_i,
        input  wire       pwrite_i,
        input  apb_data_t pwdata_i,
        output apb_data_t prdata_o,
        output logic      pready_o,
        output logic      pslverr_o,

        input  kbd_btn_t  kbd_btn_i,
        output logic      swap_o,
        output logic      kbd_en_o
);

        logic              access;
        logic              sel_ctrl;
        logic              sel_keys;
        logic [CTRL_W-1:0] ctrl_q;

        // ========================================
        // Address decode
        // ========================================
        assign access   = psel_i & penable_i;
        assign sel_ctrl = paddr_i == ADDR_CTRL;
        assign sel_keys = paddr_i == ADDR_KEYS;

        assign pready_o  = access;
        assign pslverr_o = access & ~(sel_ctrl | sel_keys);

        // ========================================
        // CTRL register
        // ========================================
        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        ctrl_q <= '0;
                end else if (access && pwrite_i && sel_ctrl) begin
                        ctrl_q <= pwdata_i[CTRL_W-1:0];
                end
        end

        // Writes to KEYS fall through here with no effect
        always_comb begin
                if (sel_ctrl) begin
                        prdata_o = {{(APB_DATA_W-CTRL_W){1'b0}}, ctrl_q};
                end else if (sel_keys) begin
                        prdata_o = {{(APB_DATA_W-KBD_BTN_W){1'b0}}, kbd_btn_i};
                end else begin
                        prdata_o = '0;
                end
        end

        assign swap_o   = ctrl_q[CTRL_SWAP];
        assign kbd_en_o = ctrl_q[CTRL_KBD_EN];

endmodule

`default_nettype wire

//--- hw/cv_pkg.sv
`default_nettype none

package cv_pkg;

        // ========================================
        // Keypad request vector, active high
        // ========================================
        typedef logic [19:0] keypad_t;

        // Digits 0 to 9 sit on bits 0 to 9
        localparam int NUM_DIGITS = 10;
        localparam int KP_STAR    = 10;
        localparam int KP_NUMBER  = 11;
        localparam int KP_PT      = 12;
        localparam int KP_BT      = 13;
        // Up, down, left, right follow in that order
        localparam int KP_UP      = 14;
        localparam int KP_FIRE1   = 18;
        localparam int KP_FIRE2   = 19;

        // ========================================
        // Controller port codes
        // ========================================
        typedef logic [3:0] port_code_t;

        localparam port_code_t KEY_0      = 4'b0011;
        localparam port_code_t KEY_1      = 4'b1110;
        localparam port_code_t KEY_2      = 4'b1101;
        localparam port_code_t KEY_3      = 4'b0110;
        localparam port_code_t KEY_4      = 4'b0001;
        localparam port_code_t KEY_5      = 4'b1001;
        localparam port_code_t KEY_6      = 4'b0111;
        localparam port_code_t KEY_7      = 4'b1100;
        localparam port_code_t KEY_8      = 4'b1000;
        localparam port_code_t KEY_9      = 4'b1011;
        localparam port_code_t KEY_STAR   = 4'b1010;
        localparam port_code_t KEY_NUMBER = 4'b0101;
        localparam port_code_t KEY_PT     = 4'b0100;
        localparam port_code_t KEY_BT     = 4'b0010;
        localparam port_code_t KEY_NONE   = 4'b1111;

        // Code for each keypad index, 0 through KP_BT
        localparam port_code_t KEY_LUT [0:KP_BT] = '{
                KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6,
                KEY_7, KEY_8, KEY_9, KEY_STAR, KEY_NUMBER, KEY_PT, KEY_BT
        };

        // ========================================
        // Game-pad word, host layout
        // ========================================
        typedef logic [19:0] joy_t;

        localparam int JOY_RIGHT  = 0;
        localparam int JOY_LEFT   = 1;
        localparam int JOY_DOWN   = 2;
        localparam int JOY_UP     = 3;
        localparam int JOY_FIRE1  = 4;
        localparam int JOY_FIRE2  = 5;
        localparam int JOY_STAR   = 6;
        localparam int JOY_NUMBER = 7;
        localparam int JOY_DIGIT0 = 8;
        localparam int JOY_PT     = 18;
        localparam int JOY_BT     = 19;

        // Emulated keyboard buttons, digits on bits 0 to 9
        localparam int KBD_BTN_W = 13;
        typedef logic [KBD_BTN_W-1:0] kbd_btn_t;

        localparam int BTN_STAR  = 10;
        localparam int BTN_SHIFT = 11;
        localparam int BTN_MINUS = 12;

        // ========================================
        // APB register map
        // ========================================
        localparam int APB_ADDR_W = 4;
        localparam int APB_DATA_W = 32;
        typedef logic [APB_ADDR_W-1:0] apb_addr_t;
        typedef logic [APB_DATA_W-1:0] apb_data_t;

        localparam apb_addr_t ADDR_CTRL = 4'h0;
        localparam apb_addr_t ADDR_KEYS = 4'h4;

        // CTRL fields
        localparam int CTRL_W      = 2;
        localparam int CTRL_SWAP   = 0;
        localparam int CTRL_KBD_EN = 1;

endpackage

`default_nettype wire

//--- hw/cv_port_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module cv_port_encoder
        import cv_pkg::*;
(
        input  keypad_t           keypad_i,
        cv_port_if.encoder        port
);

        port_code_t kp_code;
        port_code_t kp_lines;
        port_code_t joy_lines;
        logic       kp_fire_n;
        logic       joy_fire_n;

        // ========================================
        // Keypad priority encoder
        // ========================================
        always_comb begin
                kp_code = KEY_NONE;
                // Walk down so the lowest set index is the one kept
                for (int i = KP_BT; i >= 0; i--) begin
                        if (keypad_i[i]) begin
                                kp_code = KEY_LUT[i];
                        end
                end
        end

        // Keypad part, active while the keypad strobe is low
        always_comb begin
                if (!port.strobe_kp_n) begin
                        kp_lines  = kp_code;
                        kp_fire_n = ~keypad_i[KP_FIRE2];
                end else begin
                        kp_lines  = '1;
                        kp_fire_n = 1'b1;
                end
        end

        // Joystick part, up/down/left/right on lines 3..0
        always_comb begin
                if (!port.strobe_joy_n) begin
                        joy_lines  = ~{keypad_i[KP_UP],
                                       keypad_i[KP_UP + 1],
                                       keypad_i[KP_UP + 2],
                                       keypad_i[KP_UP + 3]};
                        joy_fire_n = ~keypad_i[KP_FIRE1];
                end else begin
                        joy_lines  = '1;
                        joy_fire_n = 1'b1;
                end
        end

        // Open-collector style merge of both parts
        assign port.lines  = kp_lines & joy_lines;
        assign port.fire_n = kp_fire_n & joy_fire_n;

endmodule

`default_nettype wire

//--- hw/cv_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// One controller port between console side and encoder
interface cv_port_if
        import cv_pkg::*;
();

        // Active-low strobes from the console
        logic       strobe_kp_n;
        logic       strobe_joy_n;

        // Port lines and fire, driven by the encoder
        port_code_t lines;
        logic       fire_n;

        modport encoder (
                input  strobe_kp_n,
                input  strobe_joy_n,
                output lines,
                output fire_n
        );

        modport console (
                output strobe_kp_n,
                output strobe_joy_n,
                input  lines,
                input  fire_n
        );

endinterface

`default_nettype wire

//--- hw/pad_router.sv
`timescale 1ns/1ps
`default_nettype none

module pad_router
        import cv_pkg::*;
(
        input  wire      swap_i,
        input  wire      kbd_en_i,
        input  kbd_btn_t kbd_btn_i,
        input  joy_t     joy0_i,
        input  joy_t     joy1_i,
        output keypad_t  keypad_a_o,
        output keypad_t  keypad_b_o
);

        joy_t    joy_a;
        joy_t    joy_b;
        keypad_t kbd_kp;

        // Host game-pad layout into keypad order
        function automatic keypad_t remap(input joy_t j);
                keypad_t kp;

                kp                     = '0;
                kp[NUM_DIGITS-1:0]     = j[JOY_DIGIT0 +: NUM_DIGITS];
                kp[KP_STAR]            = j[JOY_STAR];
                kp[KP_NUMBER]          = j[JOY_NUMBER];
                kp[KP_PT]              = j[JOY_PT];
                kp[KP_BT]              = j[JOY_BT];
                kp[KP_UP]              = j[JOY_UP];
                kp[KP_UP + 1]          = j[JOY_DOWN];
                kp[KP_UP + 2]          = j[JOY_LEFT];
                kp[KP_UP + 3]          = j[JOY_RIGHT];
                kp[KP_FIRE1]           = j[JOY_FIRE1];
                kp[KP_FIRE2]           = j[JOY_FIRE2];
                return kp;
        endfunction

        // Player order
        assign joy_a = swap_i ? joy1_i : joy0_i;
        assign joy_b = swap_i ? joy0_i : joy1_i;

        // ========================================
        // Keyboard contribution, same for both players
        // ========================================
        always_comb begin
                kbd_kp = '0;
                if (kbd_en_i) begin
                        kbd_kp[NUM_DIGITS-1:0] = kbd_btn_i[NUM_DIGITS-1:0];
                        // Shift+8 is star, shift+3 is number
                        kbd_kp[KP_STAR]   = kbd_btn_i[BTN_STAR] |
                                            (kbd_btn_i[BTN_SHIFT] & kbd_btn_i[8]);
                        kbd_kp[KP_NUMBER] = kbd_btn_i[BTN_MINUS] |
                                            (kbd_btn_i[BTN_SHIFT] & kbd_btn_i[3]);
                end
        end

        assign keypad_a_o = remap(joy_a) | kbd_kp;
        assign keypad_b_o = remap(joy_b) | kbd_kp;

endmodule

`default_nettype wire

//--- hw/ps2_keypad_emu.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keypad_emu
        import cv_pkg::*;
        import ps2_pkg::*;
(
        input  wire        clk_sys,
        input  wire        rst_i,
        input  ps2_event_t ps2_key_i,
        output kbd_btn_t   kbd_btn_o
);

        logic       toggle_q;
        kbd_btn_t   kbd_btn_q;
        scan_code_t code;
        logic       new_event;
        logic       hit;
        int         btn_idx;

        assign code      = ps2_key_i[$bits(scan_code_t)-1:0];
        assign new_event = ps2_key_i[PS2_TOGGLE] != toggle_q;

        // ========================================
        // Scan code to button index
        // ========================================
        always_comb begin
                hit     = 1'b1;
                btn_idx = 0;
                case (code)
                        SC_TOP_0, SC_PAD_0:    btn_idx = 0;
                        SC_TOP_1, SC_PAD_1:    btn_idx = 1;
                        SC_TOP_2, SC_PAD_2:    btn_idx = 2;
                        SC_TOP_3, SC_PAD_3:    btn_idx = 3;
                        SC_TOP_4, SC_PAD_4:    btn_idx = 4;
                        SC_TOP_5, SC_PAD_5:    btn_idx = 5;
                        SC_TOP_6, SC_PAD_6:    btn_idx = 6;
                        SC_TOP_7, SC_PAD_7:    btn_idx = 7;
                        SC_TOP_8, SC_PAD_8:    btn_idx = 8;
                        SC_TOP_9, SC_PAD_9:    btn_idx = 9;
                        SC_STAR:               btn_idx = BTN_STAR;
                        SC_LSHIFT, SC_RSHIFT:  btn_idx = BTN_SHIFT;
                        SC_MINUS:              btn_idx = BTN_MINUS;
                        // Anything else leaves the buttons alone
                        default:               hit = 1'b0;
                endcase
        end

        // ========================================
        // Event detect and button state
        // ========================================
        always_ff @(posedge clk_sys) begin
                // Tracks the input in reset too, so no event fires on release
                toggle_q <= ps2_key_i[PS2_TOGGLE];

                if (rst_i) begin
                        kbd_btn_q <= '0;
                end else if (new_event && hit) begin
                        kbd_btn_q[btn_idx] <= ps2_key_i[PS2_PRESSED];
                end
        end

        assign kbd_btn_o = kbd_btn_q;

endmodule

`default_nettype wire

//--- hw/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

        // Toggle on bit 10, pressed on bit 9, code on bits 8:0
        typedef logic [10:0] ps2_event_t;

        localparam int PS2_TOGGLE  = 10;
        localparam int PS2_PRESSED = 9;

        // Extension bit 8 is not part of the match
        typedef logic [7:0] scan_code_t;

        // ========================================
        // Top-row digits
        // ========================================
        localparam scan_code_t SC_TOP_0 = 8'h45;
        localparam scan_code_t SC_TOP_1 = 8'h16;
        localparam scan_code_t SC_TOP_2 = 8'h1E;
        localparam scan_code_t SC_TOP_3 = 8'h26;
        localparam scan_code_t SC_TOP_4 = 8'h25;
        localparam scan_code_t SC_TOP_5 = 8'h2E;
        localparam scan_code_t SC_TOP_6 = 8'h36;
        localparam scan_code_t SC_TOP_7 = 8'h3D;
        localparam scan_code_t SC_TOP_8 = 8'h3E;
        localparam scan_code_t SC_TOP_9 = 8'h46;

        // ========================================
        // Numeric pad
        // ========================================
        localparam scan_code_t SC_PAD_0 = 8'h70;
        localparam scan_code_t SC_PAD_1 = 8'h69;
        localparam scan_code_t SC_PAD_2 = 8'h72;
        localparam scan_code_t SC_PAD_3 = 8'h7A;
        localparam scan_code_t SC_PAD_4 = 8'h6B;
        localparam scan_code_t SC_PAD_5 = 8'h73;
        localparam scan_code_t SC_PAD_6 = 8'h74;
        localparam scan_code_t SC_PAD_7 = 8'h6C;
        localparam scan_code_t SC_PAD_8 = 8'h75;
        localparam scan_code_t SC_PAD_9 = 8'h7D;

        localparam scan_code_t SC_STAR   = 8'h7C;
        localparam scan_code_t SC_LSHIFT = 8'h12;
        localparam scan_code_t SC_RSHIFT = 8'h59;
        // Minus on the numeric pad
        localparam scan_code_t SC_MINUS  = 8'h7B;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
        --top-module coleco_ctrl_tb \
        -f coleco_ctrl.f \
        -o coleco_ctrl_sim

./obj_dir/coleco_ctrl_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed"
        exit 1
fi
